/* verilog/uart_macros.svh */
`ifndef UART_MACROS_SVH
`define UART_MACROS_SVH

`define UART_ADDR_W 5

// Register offsets on the APB port
`define UART_REG_CTRL   5'h00 // Bit 0 rx_en and bit 1 tx_en
`define UART_REG_BAUD   5'h04 // Clocks per bit in the low half
`define UART_REG_TXDATA 5'h08
`define UART_REG_RXDATA 5'h0C
`define UART_REG_STATUS 5'h10 // Bit 0 tx_busy, bit 1 rx_valid, bit 2 rx_overrun

`define UART_DEFAULT_DIV 16'd16

`endif

/* verilog/uart_pkg.sv */
`default_nettype none

`include "uart_macros.svh"

package uart_pkg;

  typedef logic [7:0]              uart_byte_t;
  typedef logic [15:0]             uart_div_t; // Clocks per bit
  typedef logic [`UART_ADDR_W-1:0] apb_addr_t;
  typedef logic [31:0]             apb_data_t;

  typedef enum logic [2:0] {rx_idle, rx_start, rx_data, rx_stop, rx_cleanup} rx_state_t;
  typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_t;

endpackage

`default_nettype wire

/* verilog/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  rx_serial,
  input  logic                  rx_en,
  input  uart_pkg::uart_div_t   clks_per_bit,
  output uart_pkg::uart_byte_t  rx_byte,
  output logic                  rx_done
);

  import uart_pkg::*;

  rx_state_t  state;
  uart_div_t  cnt;
  uart_div_t  half_bit;
  logic [2:0] bit_idx;
  logic       bit_end;
  logic       rx_meta;
  logic       rx_sync;

  // Middle of the start bit and end of a full bit period
  assign half_bit = (clks_per_bit - 16'd1) >> 1;
  assign bit_end  = (cnt == clks_per_bit - 16'd1);

  // Two flop synchronizer, line idles high
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
    end
    else
    begin
      rx_meta <= rx_serial;
      rx_sync <= rx_meta;
    end
  end

  // Disabling the receiver drops any frame in progress
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni || !rx_en)
    begin
      state   <= rx_idle;
      cnt     <= '0;
      bit_idx <= '0;
      rx_done <= 1'b0;
    end
    else
    begin
      rx_done <= 1'b0;
      case (state)
        rx_idle:
        begin
          cnt     <= '0;
          bit_idx <= '0;
          if (!rx_sync) // Falling edge of a start bit
            state <= rx_start;
        end

        rx_start:
        begin
          if (cnt == half_bit)
          begin
            cnt   <= '0;
            state <= rx_sync ? rx_idle : rx_data; // Glitch if already high again
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        // Each sample lands in the middle of a data bit
        rx_data:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7)
              state <= rx_stop;
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        rx_stop:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            rx_done <= 1'b1;
            state   <= rx_cleanup;
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        rx_cleanup:
          state <= rx_idle; // One cycle before the next start can be seen

        default:
          state <= rx_idle;
      endcase
    end
  end

  // LSB arrives first so shift in from the top
  always_ff @(posedge clk_i)
  begin
    if (state == rx_data && bit_end)
      rx_byte <= {rx_sync, rx_byte[7:1]};
  end

endmodule

`default_nettype wire

/* verilog/uart_tx.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  tx_en,
  input  uart_pkg::uart_div_t   clks_per_bit,
  input  logic                  tx_start,
  input  uart_pkg::uart_byte_t  tx_byte,
  output logic                  tx_serial,
  output logic                  tx_busy
);

  import uart_pkg::*;

  tx_state_t  state;
  uart_div_t  cnt;
  uart_byte_t shreg;
  logic [2:0] bit_idx;
  logic       bit_end;
  logic       launch;

  assign bit_end = (cnt == clks_per_bit - 16'd1);
  assign launch  = (state == tx_idle) && tx_start && tx_en;

  // The port tx_start hides the state name, hence uart_pkg::tx_start below
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      state     <= tx_idle;
      cnt       <= '0;
      bit_idx   <= '0;
      tx_serial <= 1'b1;
      tx_busy   <= 1'b0;
    end
    else
    begin
      case (state)
        tx_idle:
        begin
          cnt     <= '0;
          bit_idx <= '0;
          if (launch)
          begin
            state     <= uart_pkg::tx_start;
            tx_serial <= 1'b0; // Start bit
            tx_busy   <= 1'b1;
          end
        end

        uart_pkg::tx_start:
        begin
          if (bit_end)
          begin
            cnt       <= '0;
            tx_serial <= shreg[0];
            state     <= tx_data;
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        tx_data:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            bit_idx <= bit_idx + 3'd1;
            if (bit_idx == 3'd7)
            begin
              tx_serial <= 1'b1; // Stop bit
              state     <= tx_stop;
            end
            else
            begin
              tx_serial <= shreg[0];
            end
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        tx_stop:
        begin
          if (bit_end)
          begin
            cnt     <= '0;
            tx_busy <= 1'b0;
            state   <= tx_idle;
          end
          else
          begin
            cnt <= cnt + 16'd1;
          end
        end

        default:
          state <= tx_idle;
      endcase
    end
  end

  // Next data bit always sits in shreg[0]
  always_ff @(posedge clk_i)
  begin
    if (launch)
      shreg <= tx_byte;
    else if (bit_end && (state == uart_pkg::tx_start || state == tx_data))
      shreg <= {1'b1, shreg[7:1]};
  end

endmodule

`default_nettype wire

/* verilog/uart_apb_regs.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module uart_apb_regs (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic                  psel,
  input  logic                  penable,
  input  logic                  pwrite,
  input  uart_pkg::apb_addr_t   paddr,
  input  uart_pkg::apb_data_t   pwdata,
  input  logic                  tx_busy,
  input  uart_pkg::uart_byte_t  rx_byte,
  input  logic                  rx_done,
  output uart_pkg::apb_data_t   prdata,
  output logic                  pready,
  output logic                  pslverr,
  output logic                  rx_en,
  output logic                  tx_en,
  output uart_pkg::uart_div_t   clks_per_bit,
  output logic                  tx_start,
  output uart_pkg::uart_byte_t  tx_byte
);

  import uart_pkg::*;

  logic       access;
  logic       wr_en;
  logic       rd_en;
  logic       sel_ctrl;
  logic       sel_baud;
  logic       sel_txdata;
  logic       sel_rxdata;
  logic       sel_status;
  logic       unmapped;
  logic       tx_reject;
  logic       rx_read;
  logic       rx_valid;
  logic       rx_overrun;
  uart_byte_t rx_hold;

  assign access = psel && penable; // Access phase, always one cycle
  assign wr_en  = access && pwrite;
  assign rd_en  = access && !pwrite;

  assign sel_ctrl   = (paddr == `UART_REG_CTRL);
  assign sel_baud   = (paddr == `UART_REG_BAUD);
  assign sel_txdata = (paddr == `UART_REG_TXDATA);
  assign sel_rxdata = (paddr == `UART_REG_RXDATA);
  assign sel_status = (paddr == `UART_REG_STATUS);
  assign unmapped   = !(sel_ctrl || sel_baud || sel_txdata || sel_rxdata || sel_status);

  // Transmitter can take a byte only when enabled and idle
  assign tx_reject = sel_txdata && (tx_busy || !tx_en);
  assign rx_read   = rd_en && sel_rxdata;

  assign pready  = 1'b1;
  assign pslverr = access && (unmapped || (pwrite && tx_reject));

  // Start goes out at the access edge so the frame begins on the next cycle
  assign tx_start = wr_en && sel_txdata && !tx_reject;
  assign tx_byte  = pwdata[7:0];

  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      rx_en        <= 1'b0;
      tx_en        <= 1'b0;
      clks_per_bit <= `UART_DEFAULT_DIV;
    end
    else if (wr_en && sel_ctrl)
    begin
      rx_en <= pwdata[0];
      tx_en <= pwdata[1];
    end
    else if (wr_en && sel_baud)
    begin
      clks_per_bit <= pwdata[15:0];
    end
  end

  // A new byte wins over a read in the same cycle
  always_ff @(posedge clk_i)
  begin
    if (!rst_ni)
    begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end
    else if (rx_done)
    begin
      rx_valid   <= 1'b1;
      rx_overrun <= (rx_valid || rx_overrun) && !rx_read; // Unread byte lost
    end
    else if (rx_read)
    begin
      rx_valid   <= 1'b0;
      rx_overrun <= 1'b0;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (rx_done)
      rx_hold <= rx_byte;
  end

  // Read mux, both datapaths meet in STATUS
  always_comb
  begin
    case (paddr)
      `UART_REG_CTRL:   prdata = {30'd0, tx_en, rx_en};
      `UART_REG_BAUD:   prdata = {16'd0, clks_per_bit};
      `UART_REG_RXDATA: prdata = {24'd0, rx_hold};
      `UART_REG_STATUS: prdata = {29'd0, rx_overrun, rx_valid, tx_busy};
      default:          prdata = '0; // TXDATA reads as zero
    endcase
  end

endmodule

`default_nettype wire

/* verilog/uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_top (
  input  logic                 clk_i,
  input  logic                 rst_ni,
  input  logic                 psel,
  input  logic                 penable,
  input  logic                 pwrite,
  input  uart_pkg::apb_addr_t  paddr,
  input  uart_pkg::apb_data_t  pwdata,
  output uart_pkg::apb_data_t  prdata,
  output logic                 pready,
  output logic                 pslverr,
  input  logic                 rx_serial,
  output logic                 tx_serial
);

  import uart_pkg::*;

  logic       rx_en;
  logic       tx_en;
  logic       tx_start;
  logic       tx_busy;
  logic       rx_done;
  uart_div_t  clks_per_bit; // Shared by both directions
  uart_byte_t tx_byte;
  uart_byte_t rx_byte;

  uart_apb_regs regs_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .psel         (psel),
    .penable      (penable),
    .pwrite       (pwrite),
    .paddr        (paddr),
    .pwdata       (pwdata),
    .tx_busy      (tx_busy),
    .rx_byte      (rx_byte),
    .rx_done      (rx_done),
    .prdata       (prdata),
    .pready       (pready),
    .pslverr      (pslverr),
    .rx_en        (rx_en),
    .tx_en        (tx_en),
    .clks_per_bit (clks_per_bit),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte)
  );

  uart_rx rx_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .rx_serial    (rx_serial),
    .rx_en        (rx_en),
    .clks_per_bit (clks_per_bit),
    .rx_byte      (rx_byte),
    .rx_done      (rx_done)
  );

  uart_tx tx_i (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .tx_en        (tx_en),
    .clks_per_bit (clks_per_bit),
    .tx_start     (tx_start),
    .tx_byte      (tx_byte),
    .tx_serial    (tx_serial),
    .tx_busy      (tx_busy)
  );

endmodule

`default_nettype wire

/* sim/tb_uart_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "uart_macros.svh"

module tb_uart_top;

  import uart_pkg::*;

  typedef enum logic [2:0] {mode_loop, mode_ext, mode_pair, mode_glitch, mode_rxoff} mode_t;

  localparam int num_tests   = 10;
  localparam int max_div     = 37;
  localparam int watchdog_ns = num_tests * 12 * max_div * 4 + 8000;

  logic      clk_i = 1'b0;
  logic      rst_ni;
  logic      psel;
  logic      penable;
  logic      pwrite;
  apb_addr_t paddr;
  apb_data_t pwdata;
  apb_data_t prdata;
  logic      pready;
  logic      pslverr;
  logic      rx_serial = 1'b1; // Idle line
  logic      tx_serial;
  logic      line_bit;
  logic      loopback;
  int        errors;
  int        checks;
  int        num_added;
  int        seed;

  // Stimulus table with expected results
  string      test_name  [num_tests];
  uart_div_t  test_div   [num_tests];
  uart_byte_t test_byte  [num_tests];
  mode_t      test_mode  [num_tests];
  apb_data_t  exp_rxdata [num_tests];
  apb_data_t  exp_status [num_tests];

  uart_top dut_i (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .paddr     (paddr),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .pslverr   (pslverr),
    .rx_serial (rx_serial),
    .tx_serial (tx_serial)
  );

  always #2 clk_i = ~clk_i;

  // Line model, either the framed bit or the transmitter looped back
  always @(posedge clk_i)
    rx_serial <= loopback ? tx_serial : line_bit;

  task automatic check_value(input string name, input apb_data_t expected,
                             input apb_data_t actual);
    checks++;
    if (actual !== expected)
    begin
      $display("Mismatch in %s: expected %h, actual %h", name, expected, actual);
      errors++;
    end
  endtask

  task automatic apb_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                            output apb_data_t rdata, output logic err);
    @(posedge clk_i);
    psel    <= 1'b1; // Setup phase
    penable <= 1'b0;
    pwrite  <= wr;
    paddr   <= addr;
    pwdata  <= wdata;
    @(posedge clk_i);
    penable <= 1'b1;
    @(negedge clk_i); // Middle of the access phase
    rdata = prdata;
    err   = pslverr;
    if (!pready)
    begin
      $display("APB slave held pready low during access to offset %h", addr);
      errors++;
    end
    @(posedge clk_i);
    psel    <= 1'b0;
    penable <= 1'b0;
  endtask

  task automatic apb_write(input apb_addr_t addr, input apb_data_t data, output logic err);
    apb_data_t unused_rd;
    apb_access(1'b1, addr, data, unused_rd, err);
  endtask

  task automatic apb_read(input apb_addr_t addr, output apb_data_t data, output logic err);
    apb_access(1'b0, addr, 32'd0, data, err);
  endtask

  // 8N1 frame on the line, LSB first
  task automatic send_frame(input uart_byte_t data, input uart_div_t div);
    logic [9:0] frame;
    frame = {1'b1, data, 1'b0};
    for (int b = 0; b < 10; b++)
    begin
      @(posedge clk_i);
      line_bit <= frame[b];
      repeat (div - 16'd1) @(posedge clk_i);
    end
  endtask

  task automatic send_glitch(input uart_div_t div);
    @(posedge clk_i);
    line_bit <= 1'b0;
    repeat (div >> 2) @(posedge clk_i); // Quarter bit, well short of the mid-bit check
    line_bit <= 1'b1;
  endtask

  // Poll until a byte is held and the transmitter is quiet
  task automatic wait_rx_valid(input string name, input int limit);
    apb_data_t st;
    logic      err;
    int        polls;
    st    = '0;
    polls = 0;
    while (st[1:0] != 2'b10 && polls < limit)
    begin
      apb_read(`UART_REG_STATUS, st, err);
      polls++;
    end
    if (st[1:0] != 2'b10)
    begin
      $display("Receive timeout in %s: no rx_valid after %0d status reads", name, polls);
      errors++;
    end
  endtask

  task automatic add_test(input string name, input uart_div_t div, input uart_byte_t data,
                          input mode_t mode, input apb_data_t rxdata, input apb_data_t status);
    test_name[num_added]  = name;
    test_div[num_added]   = div;
    test_byte[num_added]  = data;
    test_mode[num_added]  = mode;
    exp_rxdata[num_added] = rxdata;
    exp_status[num_added] = status;
    num_added++;
  endtask

  task automatic fill_table();
    logic [31:0] rnd;
    uart_div_t   div;
    add_test("loop_div8", 16'd8, 8'h55, mode_loop, 32'h55, 32'd2);
    add_test("loop_div16", 16'd16, 8'hC3, mode_loop, 32'hC3, 32'd2);
    add_test("loop_div37", 16'd37, 8'h0F, mode_loop, 32'h0F, 32'd2);
    add_test("ext_lsb_first", 16'd16, 8'h4B, mode_ext, 32'h4B, 32'd2);
    add_test("overrun", 16'd16, 8'h3C, mode_pair, 32'hC3, 32'd6); // Second byte kept
    add_test("short_start", 16'd16, 8'h00, mode_glitch, 32'h00, 32'd0);
    add_test("rx_disabled", 16'd16, 8'h96, mode_rxoff, 32'h00, 32'd0);
    for (int k = 0; k < 3; k++)
    begin
      rnd = $random(seed);
      div = (k == 0) ? 16'd8 : ((k == 1) ? 16'd16 : 16'd37);
      add_test($sformatf("random_%0d", k), div, rnd[7:0], (k == 1) ? mode_ext : mode_loop,
               {24'd0, rnd[7:0]}, 32'd2);
    end
  endtask

  task automatic run_test(input int i);
    apb_data_t rd;
    logic      err;
    apb_write(`UART_REG_BAUD, {16'd0, test_div[i]}, err);
    apb_write(`UART_REG_CTRL, (test_mode[i] == mode_rxoff) ? 32'd2 : 32'd3, err);
    case (test_mode[i])
      mode_loop:
      begin
        loopback <= 1'b1;
        apb_write(`UART_REG_TXDATA, {24'd0, test_byte[i]}, err);
        check_value({test_name[i], " txdata pslverr"}, 32'd0, {31'd0, err});
      end
      mode_ext, mode_rxoff:
        send_frame(test_byte[i], test_div[i]);
      mode_pair:
      begin
        send_frame(test_byte[i], test_div[i]);
        send_frame(~test_byte[i], test_div[i]); // No read in between
      end
      default:
        send_glitch(test_div[i]);
    endcase
    if (exp_status[i][1])
    begin
      wait_rx_valid(test_name[i], 8 * int'(test_div[i]));
      apb_read(`UART_REG_STATUS, rd, err);
      check_value({test_name[i], " status"}, exp_status[i], rd);
      apb_read(`UART_REG_RXDATA, rd, err);
      check_value({test_name[i], " rxdata"}, exp_rxdata[i], rd);
      apb_read(`UART_REG_STATUS, rd, err);
      check_value({test_name[i], " status after read"}, 32'd0, rd);
    end
    else
    begin
      repeat (12 * int'(test_div[i])) @(posedge clk_i); // Longer than any frame
      apb_read(`UART_REG_STATUS, rd, err);
      check_value({test_name[i], " status"}, exp_status[i], rd);
    end
    loopback <= 1'b0;
  endtask

  task automatic check_apb_errors();
    apb_data_t rd;
    logic      err;
    apb_write(`UART_REG_BAUD, 32'd16, err);
    apb_write(`UART_REG_CTRL, 32'd1, err); // Transmitter off
    apb_write(`UART_REG_TXDATA, 32'h5A, err);
    check_value("txdata with tx_en clear pslverr", 32'd1, {31'd0, err});
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("txdata with tx_en clear tx_busy", 32'd0, {31'd0, rd[0]});
    apb_write(`UART_REG_CTRL, 32'd3, err);
    apb_write(`UART_REG_TXDATA, 32'h5A, err);
    check_value("txdata accepted pslverr", 32'd0, {31'd0, err});
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("txdata accepted tx_busy", 32'd1, {31'd0, rd[0]});
    apb_write(`UART_REG_TXDATA, 32'hA5, err);
    check_value("txdata while busy pslverr", 32'd1, {31'd0, err});
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("txdata while busy tx_busy", 32'd1, {31'd0, rd[0]});
    apb_write(5'h14, 32'hFFFF_FFFF, err);
    check_value("unmapped write pslverr", 32'd1, {31'd0, err});
    apb_read(5'h14, rd, err);
    check_value("unmapped read pslverr", 32'd1, {31'd0, err});
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("unmapped access tx_busy", 32'd1, {31'd0, rd[0]});
    repeat (10 * 16) @(posedge clk_i); // Rest of the frame
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("status after frame", 32'd0, rd);
  endtask

  initial
  begin
    #(watchdog_ns);
    $display("Watchdog expired after %0d ns before the tests finished", watchdog_ns);
    $display("Simulation failed");
    $finish;
  end

  initial
  begin
    apb_data_t rd;
    logic      err;
    rst_ni    = 1'b0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    paddr     = '0;
    pwdata    = '0;
    line_bit  = 1'b1;
    loopback  = 1'b0;
    errors    = 0;
    checks    = 0;
    num_added = 0;
    seed      = 32'h7c439d86;
    repeat (5) @(posedge clk_i);
    rst_ni <= 1'b1;

    apb_read(`UART_REG_CTRL, rd, err);
    check_value("reset ctrl", 32'd0, rd);
    apb_read(`UART_REG_BAUD, rd, err);
    check_value("reset baud", 32'd16, rd);
    apb_read(`UART_REG_STATUS, rd, err);
    check_value("reset status", 32'd0, rd);
    @(negedge clk_i);
    check_value("reset tx_serial", 32'd1, {31'd0, tx_serial});

    fill_table();
    for (int i = 0; i < num_added; i++)
      run_test(i);
    check_apb_errors();

    $display("%0d checks, %0d errors", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

`default_nettype wire

/* all.f */
+incdir+verilog
verilog/uart_pkg.sv
verilog/uart_rx.sv
verilog/uart_tx.sv
verilog/uart_apb_regs.sv
verilog/uart_top.sv
sim/tb_uart_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -f all.f --top-module tb_uart_top \
  --Mdir obj_dir -o tb_uart_top > sim.log 2>&1 &&
  ./obj_dir/tb_uart_top >> sim.log 2>&1
cat sim.log
grep -q "Simulation completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
